// ==== apb_soc_ctrl.f ====
source/soc_ctrl_regmap_pkg.sv
source/pad_cfg_pkg.sv
source/soc_reg_if.sv
source/apb_soc_ctrl_decode.sv
source/pad_ctrl_regs.sv
source/soc_boot_regs.sv
source/apb_soc_ctrl.sv
testbench/tb_clk_gen.sv
testbench/apb_soc_ctrl_assert.sv
testbench/tb_apb_soc_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_apb_soc_ctrl \
   -f apb_soc_ctrl.f -o sim_apb_soc_ctrl

./obj_dir/sim_apb_soc_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

// ==== source/apb_soc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_soc_ctrl (
   input  logic                                             HCLK,
   input  logic                                             HRESETn,

   // apb slave, zero wait states
   input  logic    [soc_ctrl_regmap_pkg::apb_addr_width-1:0] paddr_i,
   input  logic                                      [31:0] pwdata_i,
   input  logic                                             pwrite_i,
   input  logic                                             psel_i,
   input  logic                                             penable_i,
   output logic                                      [31:0] prdata_o,
   output logic                                             pready_o,
   output logic                                             pslverr_o,

   input  logic                                             sel_fll_clk_i,
   input  logic                                             fc_fetch_en_valid_i,
   input  logic                                             fc_fetch_en_i,

   output pad_cfg_pkg::pad_cfg_t [pad_cfg_pkg::nb_pads-1:0] pad_cfg_o,
   output logic              [pad_cfg_pkg::nb_pads-1:0][1:0] pad_mux_o,

   input  logic     [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] soc_jtag_reg_i,
   output logic     [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] soc_jtag_reg_o,

   output logic                                      [31:0] fc_bootaddr_o,
   output logic                                             fc_fetchen_o,
   output logic                                             cluster_pow_o,
   output logic                                             cluster_byp_o,
   output logic                                      [63:0] cluster_boot_addr_o,
   output logic                                             cluster_fetch_enable_o,
   output logic                                             cluster_rstn_o,
   output logic                                             cluster_irq_o
);

   soc_reg_if reg_bus ();   // decoder to both banks

   apb_soc_ctrl_decode u_decode (
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .reg_o     (reg_bus)
   );

   pad_ctrl_regs u_pad_regs (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .reg_i     (reg_bus),
      .pad_mux_o (pad_mux_o),
      .pad_cfg_o (pad_cfg_o)
   );

   soc_boot_regs u_boot_regs (
      .HCLK                   (HCLK),
      .HRESETn                (HRESETn),
      .reg_i                  (reg_bus),
      .sel_fll_clk_i          (sel_fll_clk_i),
      .fc_fetch_en_valid_i    (fc_fetch_en_valid_i),
      .fc_fetch_en_i          (fc_fetch_en_i),
      .soc_jtag_reg_i         (soc_jtag_reg_i),
      .soc_jtag_reg_o         (soc_jtag_reg_o),
      .fc_bootaddr_o          (fc_bootaddr_o),
      .fc_fetchen_o           (fc_fetchen_o),
      .cluster_pow_o          (cluster_pow_o),
      .cluster_byp_o          (cluster_byp_o),
      .cluster_fetch_enable_o (cluster_fetch_enable_o),
      .cluster_rstn_o         (cluster_rstn_o),
      .cluster_irq_o          (cluster_irq_o),
      .cluster_boot_addr_o    (cluster_boot_addr_o)
   );

   assign pready_o  = 1'b1;   // never stalls
   assign pslverr_o = 1'b0;   // unmapped words read zero, no error

endmodule

`default_nettype wire

// ==== source/apb_soc_ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_soc_ctrl_decode (
   input  logic                                           psel_i,
   input  logic                                           penable_i,
   input  logic                                           pwrite_i,
   input  logic [soc_ctrl_regmap_pkg::apb_addr_width-1:0] paddr_i,
   input  logic                                    [31:0] pwdata_i,
   output logic                                    [31:0] prdata_o,
   soc_reg_if.decoder                                     reg_o
);

   logic s_access;   // second cycle of an apb transfer

   assign s_access = psel_i & penable_i;

   // a write strobe only in the access phase, setup cycle is ignored
   assign reg_o.wr_en = s_access & pwrite_i;

   // byte address to word index, low two bits dropped
   assign reg_o.idx = paddr_i[soc_ctrl_regmap_pkg::reg_idx_width+1:2];

   assign reg_o.wdata = pwdata_i;

   // banks return zero for words they do not own
   assign prdata_o = reg_o.pad_rdata | reg_o.boot_rdata;

endmodule

`default_nettype wire

// ==== source/pad_cfg_pkg.sv ====
`default_nettype none

package pad_cfg_pkg;

   localparam int unsigned nb_pads           = 64;
   localparam int unsigned pads_per_fun_word = 16;   // 2 mux bits per pad
   localparam int unsigned pads_per_cfg_word = 4;    // one byte per pad

   // single pad configuration, pull-up in bit 0
   typedef struct packed {
      logic [1:0] drive;      // drive strength
      logic       slew_lim;   // slew rate limit
      logic       schmitt;    // schmitt trigger
      logic       pull_dn;
      logic       pull_up;
   } pad_cfg_t;

   // byte slot of a config word, top two bits unused
   typedef struct packed {
      logic [1:0] unused;
      pad_cfg_t   cfg;
   } pad_cfg_slot_t;

   // a config word seen whole or as four pad slots, pad 4k+0 in the low byte
   typedef union packed {
      logic [31:0]                              raw;
      pad_cfg_slot_t [pads_per_cfg_word-1:0]    slot;
   } pad_cfg_word_u;

   localparam pad_cfg_t pad_cfg_reset = 6'b11_1111;   // everything enabled

endpackage

`default_nettype wire

// ==== source/pad_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_regs (
   input  logic                                                HCLK,
   input  logic                                                HRESETn,
   soc_reg_if.pad_bank                                         reg_i,
   output logic         [pad_cfg_pkg::nb_pads-1:0][1:0]        pad_mux_o,
   output pad_cfg_pkg::pad_cfg_t [pad_cfg_pkg::nb_pads-1:0]    pad_cfg_o
);

   // pad mux words, pad 16w+k sits in bits 2k+1:2k of word w
   logic [pad_cfg_pkg::nb_pads/pad_cfg_pkg::pads_per_fun_word-1:0][31:0] r_pad_fun;

   pad_cfg_pkg::pad_cfg_t [pad_cfg_pkg::nb_pads-1:0] r_pad_cfg;

   pad_cfg_pkg::pad_cfg_word_u s_cfg_wr;   // incoming word split into slots
   pad_cfg_pkg::pad_cfg_word_u s_cfg_rd;   // read word rebuilt from slots

   assign s_cfg_wr.raw = reg_i.wdata;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_pad_fun <= '0;
         r_pad_cfg <= {pad_cfg_pkg::nb_pads{pad_cfg_pkg::pad_cfg_reset}};
      end
      else if (reg_i.wr_en)
      begin
         for (int w = 0; w < pad_cfg_pkg::nb_pads / pad_cfg_pkg::pads_per_fun_word; w++)
         begin
            if (reg_i.idx == soc_ctrl_regmap_pkg::reg_idx_t'(
                  soc_ctrl_regmap_pkg::reg_padfun_base + w))
               r_pad_fun[w] <= reg_i.wdata;
         end
         for (int c = 0; c < pad_cfg_pkg::nb_pads / pad_cfg_pkg::pads_per_cfg_word; c++)
         begin
            if (reg_i.idx == soc_ctrl_regmap_pkg::reg_idx_t'(
                  soc_ctrl_regmap_pkg::reg_padcfg_base + c))
            begin
               // unused slot bits are dropped here
               for (int s = 0; s < pad_cfg_pkg::pads_per_cfg_word; s++)
                  r_pad_cfg[c*pad_cfg_pkg::pads_per_cfg_word+s] <= s_cfg_wr.slot[s].cfg;
            end
         end
      end
   end

   always_comb
   begin
      reg_i.pad_rdata = '0;
      s_cfg_rd.raw    = '0;   // unused slot bits read as zero
      for (int w = 0; w < pad_cfg_pkg::nb_pads / pad_cfg_pkg::pads_per_fun_word; w++)
      begin
         if (reg_i.idx == soc_ctrl_regmap_pkg::reg_idx_t'(
               soc_ctrl_regmap_pkg::reg_padfun_base + w))
            reg_i.pad_rdata = r_pad_fun[w];
      end
      for (int c = 0; c < pad_cfg_pkg::nb_pads / pad_cfg_pkg::pads_per_cfg_word; c++)
      begin
         if (reg_i.idx == soc_ctrl_regmap_pkg::reg_idx_t'(
               soc_ctrl_regmap_pkg::reg_padcfg_base + c))
         begin
            for (int s = 0; s < pad_cfg_pkg::pads_per_cfg_word; s++)
               s_cfg_rd.slot[s].cfg = r_pad_cfg[c*pad_cfg_pkg::pads_per_cfg_word+s];
            reg_i.pad_rdata = s_cfg_rd.raw;
         end
      end
   end

   assign pad_mux_o = r_pad_fun;   // same bit layout, 128 bits each
   assign pad_cfg_o = r_pad_cfg;

endmodule

`default_nettype wire

// ==== source/soc_boot_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_boot_regs (
   input  logic                                          HCLK,
   input  logic                                          HRESETn,
   soc_reg_if.boot_bank                                  reg_i,
   input  logic                                          sel_fll_clk_i,
   input  logic                                          fc_fetch_en_valid_i,
   input  logic                                          fc_fetch_en_i,
   input  logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] soc_jtag_reg_i,
   output logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] soc_jtag_reg_o,
   output logic                                   [31:0] fc_bootaddr_o,
   output logic                                          fc_fetchen_o,
   output logic                                          cluster_pow_o,
   output logic                                          cluster_byp_o,
   output logic                                          cluster_fetch_enable_o,
   output logic                                          cluster_rstn_o,
   output logic                                          cluster_irq_o,
   output logic                                   [63:0] cluster_boot_addr_o
);

   logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] r_jtag_rego;
   logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] r_jtag_meta;   // first sync stage
   logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] r_jtag_sync;

   logic [31:0] r_bootaddr;
   logic        r_fetchen;
   logic [31:0] r_corestatus;
   logic        r_cluster_byp;
   logic        r_cluster_pow;
   logic        r_cluster_fetch_en;
   logic        r_cluster_rstn;
   logic        r_cluster_irq;
   logic [63:0] r_cluster_boot;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_jtag_meta        <= '0;
         r_jtag_sync        <= '0;
         r_jtag_rego        <= '0;
         r_bootaddr         <= soc_ctrl_regmap_pkg::fc_boot_reset;
         r_fetchen          <= 1'b0;   // fc stays idle until enabled
         r_corestatus       <= '0;
         r_cluster_byp      <= 1'b1;
         r_cluster_pow      <= 1'b0;
         r_cluster_fetch_en <= 1'b0;
         r_cluster_rstn     <= 1'b1;
         r_cluster_irq      <= 1'b0;
         r_cluster_boot     <= '0;
      end
      else
      begin
         r_jtag_meta <= soc_jtag_reg_i;
         r_jtag_sync <= r_jtag_meta;

         // pin pair loads fetch enable, an apb write below takes priority
         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i;

         if (reg_i.wr_en)
         begin
            case (reg_i.idx)
               soc_ctrl_regmap_pkg::reg_fcboot:        r_bootaddr <= reg_i.wdata;
               soc_ctrl_regmap_pkg::reg_fcfetch:       r_fetchen <= reg_i.wdata[0];
               soc_ctrl_regmap_pkg::reg_jtagreg:
                  r_jtag_rego <= reg_i.wdata[soc_ctrl_regmap_pkg::jtag_reg_size-1:0];
               soc_ctrl_regmap_pkg::reg_corestatus:    r_corestatus <= reg_i.wdata;
               soc_ctrl_regmap_pkg::reg_cluster_ctrl:
               begin
                  r_cluster_byp      <= reg_i.wdata[0];
                  r_cluster_pow      <= reg_i.wdata[1];
                  r_cluster_fetch_en <= reg_i.wdata[2];
                  r_cluster_rstn     <= reg_i.wdata[3];
               end
               soc_ctrl_regmap_pkg::reg_cluster_irq:   r_cluster_irq <= reg_i.wdata[0];
               soc_ctrl_regmap_pkg::reg_cluster_boot0: r_cluster_boot[31:0] <= reg_i.wdata;
               soc_ctrl_regmap_pkg::reg_cluster_boot1: r_cluster_boot[63:32] <= reg_i.wdata;
               default: ;   // includes the cs_ro mirror
            endcase
         end
      end
   end

   always_comb
   begin
      case (reg_i.idx)
         soc_ctrl_regmap_pkg::reg_info:
            reg_i.boot_rdata = {16'(soc_ctrl_regmap_pkg::nb_cores),
                                16'(soc_ctrl_regmap_pkg::nb_clusters)};
         soc_ctrl_regmap_pkg::reg_fcboot:        reg_i.boot_rdata = r_bootaddr;
         soc_ctrl_regmap_pkg::reg_jtagreg:       reg_i.boot_rdata = 32'({r_jtag_sync, r_jtag_rego});
         soc_ctrl_regmap_pkg::reg_corestatus,
         soc_ctrl_regmap_pkg::reg_cs_ro:         reg_i.boot_rdata = r_corestatus;
         soc_ctrl_regmap_pkg::reg_clksel:        reg_i.boot_rdata = {31'h0, sel_fll_clk_i};
         soc_ctrl_regmap_pkg::reg_cluster_ctrl:
            reg_i.boot_rdata = {28'h0, r_cluster_rstn, r_cluster_fetch_en,
                                r_cluster_pow, r_cluster_byp};
         soc_ctrl_regmap_pkg::reg_cluster_irq:   reg_i.boot_rdata = {31'h0, r_cluster_irq};
         soc_ctrl_regmap_pkg::reg_cluster_boot0: reg_i.boot_rdata = r_cluster_boot[31:0];
         soc_ctrl_regmap_pkg::reg_cluster_boot1: reg_i.boot_rdata = r_cluster_boot[63:32];
         default:                                reg_i.boot_rdata = '0;
      endcase
   end

   assign soc_jtag_reg_o         = r_jtag_rego;
   assign fc_bootaddr_o          = r_bootaddr;
   assign fc_fetchen_o           = r_fetchen;
   assign cluster_pow_o          = r_cluster_pow;
   assign cluster_byp_o          = r_cluster_byp;
   assign cluster_fetch_enable_o = r_cluster_fetch_en;
   assign cluster_rstn_o         = r_cluster_rstn;
   assign cluster_irq_o          = r_cluster_irq;
   assign cluster_boot_addr_o    = r_cluster_boot;

endmodule

`default_nettype wire

// ==== source/soc_ctrl_regmap_pkg.sv ====
`default_nettype none

package soc_ctrl_regmap_pkg;

   // APB side
   localparam int unsigned apb_addr_width = 12;   // 4 KB slave window
   localparam int unsigned reg_idx_width  = 7;    // word index from paddr[8:2]

   typedef logic [reg_idx_width-1:0] reg_idx_t;

   // word indices, byte offset is index * 4
   localparam reg_idx_t reg_info          = 7'd0;    // core and cluster counts
   localparam reg_idx_t reg_fcboot        = 7'd1;    // fc boot address
   localparam reg_idx_t reg_fcfetch       = 7'd2;    // fc fetch enable
   localparam reg_idx_t reg_padfun_base   = 7'd4;    // 4 words of pad mux
   localparam reg_idx_t reg_padcfg_base   = 7'd8;    // 16 words of pad config
   localparam reg_idx_t reg_cluster_ctrl  = 7'd28;
   localparam reg_idx_t reg_jtagreg       = 7'd29;
   localparam reg_idx_t reg_cluster_irq   = 7'd31;
   localparam reg_idx_t reg_cluster_boot0 = 7'd32;   // low half of boot address
   localparam reg_idx_t reg_cluster_boot1 = 7'd33;   // high half
   localparam reg_idx_t reg_corestatus    = 7'd40;   // eoc in bit 31
   localparam reg_idx_t reg_cs_ro         = 7'd48;   // read-only mirror
   localparam reg_idx_t reg_clksel        = 7'd50;

   // system size
   localparam int unsigned nb_cores    = 4;
   localparam int unsigned nb_clusters = 0;

   localparam int unsigned jtag_reg_size = 8;   // width of each jtag half

   // fc fetches from here once enabled
   localparam logic [31:0] fc_boot_reset = 32'h1A00_0080;

endpackage

`default_nettype wire

// ==== source/soc_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// register access from the apb decoder out to the register banks
interface soc_reg_if;

   logic                          wr_en;        // one cycle per write access
   soc_ctrl_regmap_pkg::reg_idx_t idx;          // word index
   logic                   [31:0] wdata;
   logic                   [31:0] pad_rdata;    // zero unless pad bank owns idx
   logic                   [31:0] boot_rdata;   // zero unless boot bank owns idx

   modport decoder (
      output wr_en, idx, wdata,
      input  pad_rdata, boot_rdata
   );

   modport pad_bank (
      input  wr_en, idx, wdata,
      output pad_rdata
   );

   modport boot_bank (
      input  wr_en, idx, wdata,
      output boot_rdata
   );

endinterface

`default_nettype wire

// ==== testbench/apb_soc_ctrl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_soc_ctrl_assert (
   input logic                                           HCLK,
   input logic                                           HRESETn,
   input logic                                           psel_i,
   input logic                                           penable_i,
   input logic                                           pwrite_i,
   input logic [soc_ctrl_regmap_pkg::apb_addr_width-1:0] paddr_i,
   input logic                                           pready_i,
   input logic                                           pslverr_i,
   input logic                                           fc_fetch_en_valid_i,
   input logic                                           fc_fetchen_i
);

   int unsigned fail_cnt = 0;   // read by the testbench at the end

   logic s_fetch_wr;   // write access cycle to the fetch enable word

   assign s_fetch_wr = psel_i & penable_i & pwrite_i &
      (paddr_i[soc_ctrl_regmap_pkg::reg_idx_width+1:2] == soc_ctrl_regmap_pkg::reg_fcfetch);

   ready_no_error : assert property (
      @(posedge HCLK) disable iff (!HRESETn) pready_i && !pslverr_i)
   else
   begin
      fail_cnt++;
      $error("pready_o low or pslverr_o high outside reset");
   end

   // fetch enable moves only on an apb write or the pin pair
   fetchen_source : assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      (fc_fetchen_i != $past(fc_fetchen_i)) |-> $past(s_fetch_wr || fc_fetch_en_valid_i))
   else
   begin
      fail_cnt++;
      $error("fc_fetchen_o changed without a write or a valid pulse");
   end

endmodule

`default_nettype wire

// ==== testbench/tb_apb_soc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_apb_soc_ctrl;

   localparam int unsigned test_cycles    = 400;   // rough length of all tests
   localparam int unsigned timeout_cycles = 5 * test_cycles;

   logic                                            HCLK;
   logic                                            HRESETn;
   logic    [soc_ctrl_regmap_pkg::apb_addr_width-1:0] paddr;
   logic                                     [31:0] pwdata;
   logic                                            pwrite;
   logic                                            psel;
   logic                                            penable;
   logic                                     [31:0] prdata;
   logic                                            pready;
   logic                                            pslverr;
   logic                                            sel_fll_clk;
   logic                                            fc_fetch_en_valid;
   logic                                            fc_fetch_en;
   pad_cfg_pkg::pad_cfg_t [pad_cfg_pkg::nb_pads-1:0] pad_cfg;
   logic             [pad_cfg_pkg::nb_pads-1:0][1:0] pad_mux;
   logic     [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] jtag_in;
   logic     [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] jtag_out;
   logic                                     [31:0] fc_bootaddr;
   logic                                            fc_fetchen;
   logic                                            cluster_pow;
   logic                                            cluster_byp;
   logic                                     [63:0] cluster_boot_addr;
   logic                                            cluster_fetch_enable;
   logic                                            cluster_rstn;
   logic                                            cluster_irq;

   logic [31:0] shadow [0:127];   // expected read value of every word index
   logic [31:0] lcg_state;
   int unsigned cycle_count  = 0;
   int unsigned err_count    = 0;
   int unsigned check_count  = 0;
   int unsigned test_count   = 0;
   int unsigned failed_tests = 0;

   tb_clk_gen u_clk_gen (
      .HCLK    (HCLK),
      .HRESETn (HRESETn)
   );

   apb_soc_ctrl dut (
      .HCLK                   (HCLK),
      .HRESETn                (HRESETn),
      .paddr_i                (paddr),
      .pwdata_i               (pwdata),
      .pwrite_i               (pwrite),
      .psel_i                 (psel),
      .penable_i              (penable),
      .prdata_o               (prdata),
      .pready_o               (pready),
      .pslverr_o              (pslverr),
      .sel_fll_clk_i          (sel_fll_clk),
      .fc_fetch_en_valid_i    (fc_fetch_en_valid),
      .fc_fetch_en_i          (fc_fetch_en),
      .pad_cfg_o              (pad_cfg),
      .pad_mux_o              (pad_mux),
      .soc_jtag_reg_i         (jtag_in),
      .soc_jtag_reg_o         (jtag_out),
      .fc_bootaddr_o          (fc_bootaddr),
      .fc_fetchen_o           (fc_fetchen),
      .cluster_pow_o          (cluster_pow),
      .cluster_byp_o          (cluster_byp),
      .cluster_boot_addr_o    (cluster_boot_addr),
      .cluster_fetch_enable_o (cluster_fetch_enable),
      .cluster_rstn_o         (cluster_rstn),
      .cluster_irq_o          (cluster_irq)
   );

   bind apb_soc_ctrl apb_soc_ctrl_assert u_assert (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .psel_i              (psel_i),
      .penable_i           (penable_i),
      .pwrite_i            (pwrite_i),
      .paddr_i             (paddr_i),
      .pready_i            (pready_o),
      .pslverr_i           (pslverr_o),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetchen_i        (fc_fetchen_o)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic soc_ctrl_regmap_pkg::reg_idx_t offset_idx(
      input soc_ctrl_regmap_pkg::reg_idx_t base, input int offset);
      return soc_ctrl_regmap_pkg::reg_idx_t'(int'(base) + offset);
   endfunction

   function automatic logic [soc_ctrl_regmap_pkg::apb_addr_width-1:0] word_addr(
      input soc_ctrl_regmap_pkg::reg_idx_t idx);
      logic [soc_ctrl_regmap_pkg::apb_addr_width-1:0] addr;
      addr = '0;
      addr[soc_ctrl_regmap_pkg::reg_idx_width+1:2] = idx;
      return addr;
   endfunction

   task automatic apb_write(input soc_ctrl_regmap_pkg::reg_idx_t idx, input logic [31:0] data);
      @(negedge HCLK);
      psel    = 1'b1;   // setup cycle
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = word_addr(idx);
      pwdata  = data;
      @(negedge HCLK);
      penable = 1'b1;   // register loads on the next rising edge
      @(negedge HCLK);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input soc_ctrl_regmap_pkg::reg_idx_t idx, output logic [31:0] data);
      @(negedge HCLK);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = word_addr(idx);
      @(negedge HCLK);
      penable = 1'b1;
      data    = prdata;   // settled since the setup cycle
      @(negedge HCLK);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("Error: %s is %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_pad_cfg(input string name, input pad_cfg_pkg::pad_cfg_t got,
                                input pad_cfg_pkg::pad_cfg_t exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("Error: %s is %h, expected %h", name, got, exp);
      end
   endtask

   task automatic expect_read(input soc_ctrl_regmap_pkg::reg_idx_t idx, input logic [31:0] exp);
      logic [31:0] rdata;
      apb_read(idx, rdata);
      check_word($sformatf("prdata_o (word %0d)", idx), rdata, exp);
   endtask

   task automatic end_test(input string name, input int unsigned errs_before);
      test_count++;
      if (err_count == errs_before)
         $display("test %s: passed", name);
      else
      begin
         failed_tests++;
         $display("test %s: failed with %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic reset_shadow();
      for (int i = 0; i < 128; i++)
         shadow[i] = '0;
      shadow[soc_ctrl_regmap_pkg::reg_info] = (32'(soc_ctrl_regmap_pkg::nb_cores) << 16) |
                                              32'(soc_ctrl_regmap_pkg::nb_clusters);
      shadow[soc_ctrl_regmap_pkg::reg_fcboot]       = 32'h1A00_0080;
      shadow[soc_ctrl_regmap_pkg::reg_cluster_ctrl] = 32'h9;   // rstn and bypass
      for (int c = 0; c < 16; c++)
         shadow[offset_idx(soc_ctrl_regmap_pkg::reg_padcfg_base, c)] = 32'h3F3F_3F3F;
   endtask

   task automatic test_reset();
      int unsigned errs;
      errs = err_count;
      expect_read(soc_ctrl_regmap_pkg::reg_info, 32'h0004_0000);
      expect_read(soc_ctrl_regmap_pkg::reg_fcboot, 32'h1A00_0080);
      expect_read(soc_ctrl_regmap_pkg::reg_cluster_ctrl, 32'h9);
      for (int c = 0; c < 16; c++)
         expect_read(offset_idx(soc_ctrl_regmap_pkg::reg_padcfg_base, c), 32'h3F3F_3F3F);
      for (int p = 0; p < pad_cfg_pkg::nb_pads; p++)
      begin
         check_word($sformatf("pad_mux_o[%0d]", p), {30'h0, pad_mux[p]}, 32'h0);
         check_pad_cfg($sformatf("pad_cfg_o[%0d]", p), pad_cfg[p],
                       pad_cfg_pkg::pad_cfg_t'(6'h3F));
      end
      check_word("fc_fetchen_o", {31'h0, fc_fetchen}, 32'h0);
      end_test("reset values", errs);
   endtask

   task automatic test_pad_mux();
      int unsigned errs;
      logic [31:0] fun_word [0:3];
      soc_ctrl_regmap_pkg::reg_idx_t idx;
      errs = err_count;
      for (int w = 0; w < 4; w++)
      begin
         fun_word[w] = lcg_next();
         idx = offset_idx(soc_ctrl_regmap_pkg::reg_padfun_base, w);
         apb_write(idx, fun_word[w]);
         shadow[idx] = fun_word[w];
      end
      for (int w = 0; w < 4; w++)
      begin
         expect_read(offset_idx(soc_ctrl_regmap_pkg::reg_padfun_base, w), fun_word[w]);
         for (int k = 0; k < 16; k++)   // pad 16w+k from bits 2k+1:2k
            check_word($sformatf("pad_mux_o[%0d]", 16*w + k), {30'h0, pad_mux[16*w + k]},
                       {30'h0, fun_word[w][2*k +: 2]});
      end
      end_test("pad mux", errs);
   endtask

   task automatic test_pad_cfg();
      int unsigned errs;
      int cfg_words [0:5] = '{0, 3, 6, 9, 12, 15};
      logic [31:0] data;
      soc_ctrl_regmap_pkg::reg_idx_t idx;
      int p;
      errs = err_count;
      foreach (cfg_words[i])
      begin
         data = lcg_next();
         idx  = offset_idx(soc_ctrl_regmap_pkg::reg_padcfg_base, cfg_words[i]);
         apb_write(idx, data);
         shadow[idx] = data & 32'h3F3F_3F3F;   // top two bits of each byte dropped
         expect_read(idx, shadow[idx]);
         for (int s = 0; s < 4; s++)
         begin
            p = 4*cfg_words[i] + s;
            check_pad_cfg($sformatf("pad_cfg_o[%0d]", p), pad_cfg[p],
                          pad_cfg_pkg::pad_cfg_t'(data[8*s +: 6]));
         end
      end
      end_test("pad config", errs);
   endtask

   task automatic test_boot_regs();
      int unsigned errs;
      logic [31:0] data;
      logic [31:0] hi;
      errs = err_count;
      data = lcg_next();
      apb_write(soc_ctrl_regmap_pkg::reg_fcboot, data);
      shadow[soc_ctrl_regmap_pkg::reg_fcboot] = data;
      check_word("fc_bootaddr_o", fc_bootaddr, data);
      expect_read(soc_ctrl_regmap_pkg::reg_fcboot, data);

      data = lcg_next();
      hi   = lcg_next();
      apb_write(soc_ctrl_regmap_pkg::reg_cluster_boot0, data);
      apb_write(soc_ctrl_regmap_pkg::reg_cluster_boot1, hi);
      shadow[soc_ctrl_regmap_pkg::reg_cluster_boot0] = data;
      shadow[soc_ctrl_regmap_pkg::reg_cluster_boot1] = hi;
      check_word("cluster_boot_addr_o[31:0]", cluster_boot_addr[31:0], data);
      check_word("cluster_boot_addr_o[63:32]", cluster_boot_addr[63:32], hi);
      expect_read(soc_ctrl_regmap_pkg::reg_cluster_boot0, data);
      expect_read(soc_ctrl_regmap_pkg::reg_cluster_boot1, hi);

      data = lcg_next();
      for (int n = 0; n < 2; n++)
      begin
         apb_write(soc_ctrl_regmap_pkg::reg_cluster_ctrl, data);
         shadow[soc_ctrl_regmap_pkg::reg_cluster_ctrl] = {28'h0, data[3:0]};
         check_word("cluster_byp_o", {31'h0, cluster_byp}, {31'h0, data[0]});
         check_word("cluster_pow_o", {31'h0, cluster_pow}, {31'h0, data[1]});
         check_word("cluster_fetch_enable_o", {31'h0, cluster_fetch_enable},
                    {31'h0, data[2]});
         check_word("cluster_rstn_o", {31'h0, cluster_rstn}, {31'h0, data[3]});
         expect_read(soc_ctrl_regmap_pkg::reg_cluster_ctrl, {28'h0, data[3:0]});
         data = ~data;   // second pass flips every control bit
      end

      apb_write(soc_ctrl_regmap_pkg::reg_cluster_irq, 32'h1);
      shadow[soc_ctrl_regmap_pkg::reg_cluster_irq] = 32'h1;
      check_word("cluster_irq_o", {31'h0, cluster_irq}, 32'h1);
      expect_read(soc_ctrl_regmap_pkg::reg_cluster_irq, 32'h1);

      data = lcg_next();
      apb_write(soc_ctrl_regmap_pkg::reg_corestatus, data);
      expect_read(soc_ctrl_regmap_pkg::reg_corestatus, data);
      expect_read(soc_ctrl_regmap_pkg::reg_cs_ro, data);
      apb_write(soc_ctrl_regmap_pkg::reg_cs_ro, ~data);   // mirror is read only
      expect_read(soc_ctrl_regmap_pkg::reg_corestatus, data);
      expect_read(soc_ctrl_regmap_pkg::reg_cs_ro, data);
      shadow[soc_ctrl_regmap_pkg::reg_corestatus] = data;
      shadow[soc_ctrl_regmap_pkg::reg_cs_ro]      = data;
      end_test("boot and cluster", errs);
   endtask

   task automatic test_jtag_fetch();
      int unsigned errs;
      logic [31:0] rnd;
      logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] jin;
      logic [soc_ctrl_regmap_pkg::jtag_reg_size-1:0] jout;
      errs = err_count;
      rnd  = lcg_next();
      jin  = rnd[soc_ctrl_regmap_pkg::jtag_reg_size-1:0];
      jout = rnd[2*soc_ctrl_regmap_pkg::jtag_reg_size-1:soc_ctrl_regmap_pkg::jtag_reg_size];
      @(negedge HCLK);
      jtag_in = jin;
      repeat (2) @(negedge HCLK);   // two synchronizer stages
      apb_write(soc_ctrl_regmap_pkg::reg_jtagreg, 32'(jout));
      check_word("soc_jtag_reg_o", 32'(jtag_out), 32'(jout));
      shadow[soc_ctrl_regmap_pkg::reg_jtagreg] = 32'({jin, jout});
      expect_read(soc_ctrl_regmap_pkg::reg_jtagreg, 32'({jin, jout}));

      @(negedge HCLK);
      fc_fetch_en_valid = 1'b1;
      fc_fetch_en       = 1'b1;
      @(negedge HCLK);
      fc_fetch_en_valid = 1'b0;
      fc_fetch_en       = 1'b0;
      check_word("fc_fetchen_o", {31'h0, fc_fetchen}, 32'h1);
      apb_write(soc_ctrl_regmap_pkg::reg_fcfetch, 32'h0);
      check_word("fc_fetchen_o", {31'h0, fc_fetchen}, 32'h0);

      @(negedge HCLK);
      sel_fll_clk = 1'b1;
      expect_read(soc_ctrl_regmap_pkg::reg_clksel, 32'h1);
      @(negedge HCLK);
      sel_fll_clk = 1'b0;
      expect_read(soc_ctrl_regmap_pkg::reg_clksel, 32'h0);
      end_test("jtag and fetch", errs);
   endtask

   task automatic test_unmapped();
      int unsigned errs;
      errs = err_count;
      apb_write(soc_ctrl_regmap_pkg::reg_idx_t'(60), 32'hFFFF_FFFF);
      // low words including index 60 read back as the model expects
      for (int i = 0; i < 64; i++)
         expect_read(soc_ctrl_regmap_pkg::reg_idx_t'(i), shadow[i]);
      end_test("unmapped word", errs);
   endtask

   always @(posedge HCLK)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   initial
   begin
      int unsigned total_errors;
      paddr             = '0;
      pwdata            = '0;
      pwrite            = 1'b0;
      psel              = 1'b0;
      penable           = 1'b0;
      sel_fll_clk       = 1'b0;
      fc_fetch_en_valid = 1'b0;
      fc_fetch_en       = 1'b0;
      jtag_in           = '0;
      lcg_state         = 32'd56;
      reset_shadow();

      @(posedge HRESETn);
      test_reset();
      test_pad_mux();
      test_pad_cfg();
      test_boot_regs();
      test_jtag_fetch();
      test_unmapped();

      total_errors = err_count + dut.u_assert.fail_cnt;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               test_count, failed_tests, check_count, err_count, dut.u_assert.fail_cnt);
      if (total_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic HCLK,
   output logic HRESETn
);

   initial
   begin
      HCLK    = 1'b0;
      HRESETn = 1'b0;
      repeat (2) @(posedge HCLK);
      @(negedge HCLK);
      HRESETn = 1'b1;   // released after two full cycles
   end

   always #10 HCLK = ~HCLK;   // 20 ns period

endmodule

`default_nettype wire
